//--- Makefile
# Verilator build and run of the FIFO testbench
SIM  := obj_dir/fifo_sim
SRCS := $(filter-out +%,$(shell cat flist.f)) include/fifo_defs.svh

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module fifo_tb \
		-f flist.f --Mdir obj_dir -o fifo_sim

clean:
	rm -rf obj_dir

//--- flist.f
+incdir+include
logic/fifo_pkg.sv
logic/fifo_status_if.sv
logic/ram_simple_dualport.sv
logic/fifo_ram.sv
logic/fifo_stream_out.sv
logic/fifo_regs.sv
logic/fifo_top.sv
testbench/fifo_checker.sv
testbench/fifo_tb.sv

//--- include/fifo_defs.svh
// Shared defines for the streaming FIFO subsystem
// Data and pointer widths, register map, threshold reset values

`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// Stream word and RAM address widths
`define FIFO_DATA_WIDTH 16
`define FIFO_PTR_WIDTH  4

// Threshold values after reset
`define FIFO_AF_RESET   12
`define FIFO_AE_RESET   2

// Register map
`define REG_AF          2'd0
`define REG_AE          2'd1
`define REG_STATUS      2'd2
`define REG_DROPS       2'd3

`endif

//--- logic/fifo_pkg.sv
// Package with the shared types of the FIFO subsystem
// Stream word, RAM address, fill count, register types,
// output stage occupancy enum

`include "fifo_defs.svh"

package fifo_pkg;

    // One stream word
    typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

    // RAM address
    typedef logic [`FIFO_PTR_WIDTH-1:0] addr_t;

    // Fill or free count, one bit wider so the full depth fits
    typedef logic [`FIFO_PTR_WIDTH:0] count_t;

    // Register port
    typedef logic [1:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // Words held by the output stage
    typedef enum logic [1:0] {
        EMPTY,
        ONE,
        TWO
    } out_state_t;

endpackage

//--- logic/fifo_ram.sv
// RAM-backed synchronous FIFO core
// Wrapping pointers, registered flags and counts, read response valid,
// rejected-write pulse toward the status interface

`timescale 1ns/1ps

`include "fifo_defs.svh"

module fifo_ram (
    input  logic                clk,
    input  logic                reset,

    input  logic                wr_en,
    input  fifo_pkg::data_t     wr_data,
    output logic                wr_ready,

    input  logic                rd_en,
    output logic                rd_valid,
    output fifo_pkg::data_t     rd_data,

    fifo_status_if.source       status
);

    import fifo_pkg::*;

    localparam int PW    = `FIFO_PTR_WIDTH;
    localparam int DEPTH = 1 << PW;

    // --------------------
    // RAM
    // --------------------

    logic ram_wr_en;
    logic ram_rd_en;

    // Pointers carry one extra wrap bit
    logic [PW:0] wptr;
    logic [PW:0] rptr;
    logic [PW:0] next_wptr;
    logic [PW:0] next_rptr;

    ram_simple_dualport u_ram (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .wr_addr (wptr[PW-1:0]),
        .wr_data (wr_data),
        .rd_en   (ram_rd_en),
        .rd_addr (rptr[PW-1:0]),
        .rd_data (rd_data)
    );

    // --------------------
    // Pointers and flags
    // --------------------

    logic   full;
    logic   empty;
    count_t data_count;
    count_t free_count;

    // Requests are granted only against the registered flags
    assign ram_wr_en = wr_en & ~full;
    assign ram_rd_en = rd_en & ~empty;

    assign next_wptr = ram_wr_en ? wptr + 1'b1 : wptr;
    assign next_rptr = ram_rd_en ? rptr + 1'b1 : rptr;

    always_ff @(posedge clk) begin
        if (reset) begin
            wptr       <= '0;
            rptr       <= '0;
            full       <= 1'b1;
            empty      <= 1'b1;
            data_count <= '0;
            free_count <= '0;
            rd_valid   <= 1'b0;
        end else begin
            wptr       <= next_wptr;
            rptr       <= next_rptr;
            // A write closes full at once, a read frees space a cycle later
            full       <= (next_wptr[PW] != rptr[PW]) &&
                          (next_wptr[PW-1:0] == rptr[PW-1:0]);
            // A read empties at once, a written word shows a cycle later
            empty      <= (wptr == next_rptr);
            // Counts trail the pointers by one cycle
            data_count <= wptr - rptr;
            free_count <= count_t'(DEPTH) - count_t'(wptr - rptr);
            rd_valid   <= ram_rd_en;
        end
    end

    assign wr_ready = ~full;

    assign status.full       = full;
    assign status.empty      = empty;
    assign status.data_count = data_count;
    assign status.free_count = free_count;
    assign status.wr_drop    = wr_en & full;

    // --------------------
    // Assertions
    // --------------------

    a_count_sum: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (int'(data_count) + int'(free_count) == DEPTH))
        else $error("fifo_ram: data_count and free_count do not add up to the depth");

    // A granted read only ever finds a stored word
    a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> $past(wptr != rptr))
        else $error("fifo_ram: read response after a read while empty");

endmodule

//--- logic/fifo_regs.sv
// Configuration and status block
// Almost-full and almost-empty thresholds and flags,
// rejected-write counter, register read mux

`timescale 1ns/1ps

`include "fifo_defs.svh"

module fifo_regs (
    input  logic                clk,
    input  logic                reset,

    fifo_status_if.sink         status,

    input  logic                reg_wr,
    input  fifo_pkg::reg_addr_t reg_addr,
    input  fifo_pkg::reg_data_t reg_wdata,
    output fifo_pkg::reg_data_t reg_rdata,

    output logic                almost_full,
    output logic                almost_empty
);

    import fifo_pkg::*;

    count_t    af_level;
    count_t    ae_level;
    reg_data_t drops;

    // --------------------
    // Register writes
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            af_level <= count_t'(`FIFO_AF_RESET);
            ae_level <= count_t'(`FIFO_AE_RESET);
            drops    <= '0;
        end else begin
            if (reg_wr && reg_addr == `REG_AF) begin
                af_level <= reg_wdata[`FIFO_PTR_WIDTH:0];
            end
            if (reg_wr && reg_addr == `REG_AE) begin
                ae_level <= reg_wdata[`FIFO_PTR_WIDTH:0];
            end
            // Clear wins over a drop in the same cycle
            if (reg_wr && reg_addr == `REG_DROPS) begin
                drops <= '0;
            end else if (status.wr_drop && drops != '1) begin
                drops <= drops + 1'b1;
            end
        end
    end

    // Threshold compare on the registered fill count
    assign almost_full  = (status.data_count >= af_level);
    assign almost_empty = (status.data_count <= ae_level);

    // --------------------
    // Register reads
    // --------------------

    always_comb begin
        case (reg_addr)
            `REG_AF:     reg_rdata = {11'd0, af_level};
            `REG_AE:     reg_rdata = {11'd0, ae_level};
            `REG_STATUS: reg_rdata = {4'd0, status.free_count, status.data_count,
                                      status.full, status.empty};
            default:     reg_rdata = drops;
        endcase
    end

endmodule

//--- logic/fifo_status_if.sv
// FIFO status interface
// Carries flags, counts and the rejected-write pulse from the
// FIFO core to the configuration block

`timescale 1ns/1ps

interface fifo_status_if;

    import fifo_pkg::*;

    logic   full;
    logic   empty;
    count_t data_count;
    count_t free_count;

    // One pulse per write request while full
    logic   wr_drop;

    // FIFO core side
    modport source (
        output full,
        output empty,
        output data_count,
        output free_count,
        output wr_drop
    );

    // Configuration block side
    modport sink (
        input full,
        input empty,
        input data_count,
        input free_count,
        input wr_drop
    );

endinterface

//--- logic/fifo_stream_out.sv
// Output stage of the FIFO
// Two-entry buffer that turns FIFO read responses into a
// valid/ready master stream, hiding the RAM read latency

`timescale 1ns/1ps

module fifo_stream_out (
    input  logic            clk,
    input  logic            reset,

    output logic            rd_en,
    input  logic            rd_valid,
    input  fifo_pkg::data_t rd_data,

    output logic            m_valid,
    input  logic            m_ready,
    output fifo_pkg::data_t m_data
);

    import fifo_pkg::*;

    out_state_t state;
    data_t      head_data;
    data_t      tail_data;
    logic       pop;
    logic [2:0] occupied;
    logic [2:0] pending;

    assign pop = m_valid & m_ready;

    always_comb begin
        case (state)
            ONE:     occupied = 3'd1;
            TWO:     occupied = 3'd2;
            default: occupied = 3'd0;
        endcase
    end

    // Entries in use after this edge, counting the word in flight
    assign pending = occupied + {2'b00, rd_valid};
    assign rd_en   = (pending <= {2'b00, pop} + 3'd1);

    // --------------------
    // Occupancy FSM
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= EMPTY;
        end else begin
            case (state)
                EMPTY: if (rd_valid) state <= ONE;
                ONE: begin
                    if (rd_valid && !pop) begin
                        state <= TWO;
                    end else if (!rd_valid && pop) begin
                        state <= EMPTY;
                    end
                end
                TWO: if (pop && !rd_valid) state <= ONE;
                default: state <= EMPTY;
            endcase
        end
    end

    // Head entry always holds the oldest word
    always_ff @(posedge clk) begin
        case (state)
            EMPTY: if (rd_valid) head_data <= rd_data;
            ONE: begin
                if (rd_valid && pop) begin
                    head_data <= rd_data;
                end else if (rd_valid) begin
                    tail_data <= rd_data;
                end
            end
            TWO: begin
                if (pop) begin
                    head_data <= tail_data;
                    if (rd_valid) tail_data <= rd_data;
                end
            end
            default: ;
        endcase
    end

    assign m_valid = (state != EMPTY);
    assign m_data  = head_data;

    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data)))
        else $error("fifo_stream_out: output word changed while stalled");

endmodule

//--- logic/fifo_top.sv
// Top level of the streaming FIFO subsystem
// FIFO core, output stage and configuration block
// joined behind plain stream and register ports

`timescale 1ns/1ps

module fifo_top (
    input  logic                clk,
    input  logic                reset,

    // Write stream
    input  logic                s_valid,
    output logic                s_ready,
    input  fifo_pkg::data_t     s_data,

    // Read stream
    output logic                m_valid,
    input  logic                m_ready,
    output fifo_pkg::data_t     m_data,

    // Register port
    input  logic                reg_wr,
    input  fifo_pkg::reg_addr_t reg_addr,
    input  fifo_pkg::reg_data_t reg_wdata,
    output fifo_pkg::reg_data_t reg_rdata,

    output logic                almost_full,
    output logic                almost_empty
);

    import fifo_pkg::*;

    logic  rd_en;
    logic  rd_valid;
    data_t rd_data;

    fifo_status_if status_if ();

    fifo_ram u_fifo_ram (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (s_valid),
        .wr_data  (s_data),
        .wr_ready (s_ready),
        .rd_en    (rd_en),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .status   (status_if.source)
    );

    fifo_stream_out u_stream_out (
        .clk      (clk),
        .reset    (reset),
        .rd_en    (rd_en),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .m_data   (m_data)
    );

    fifo_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .status       (status_if.sink),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .almost_full  (almost_full),
        .almost_empty (almost_empty)
    );

endmodule

//--- logic/ram_simple_dualport.sv
// Simple dual-port RAM
// One synchronous write port, one registered read port

`timescale 1ns/1ps

`include "fifo_defs.svh"

module ram_simple_dualport (
    input  logic            clk,

    input  logic            wr_en,
    input  fifo_pkg::addr_t wr_addr,
    input  fifo_pkg::data_t wr_data,

    input  logic            rd_en,
    input  fifo_pkg::addr_t rd_addr,
    output fifo_pkg::data_t rd_data
);

    import fifo_pkg::*;

    localparam int DEPTH = 1 << `FIFO_PTR_WIDTH;

    data_t mem [0:DEPTH-1];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, output holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- testbench/fifo_checker.sv
// Reference model and comparisons for the FIFO testbench
// Word order queue, drop counter and threshold models,
// register read checks, error counts and the closing count line

`timescale 1ns/1ps

`include "fifo_defs.svh"

module fifo_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                s_valid,
    input  logic                s_ready,
    input  fifo_pkg::data_t     s_data,
    input  logic                m_valid,
    input  logic                m_ready,
    input  fifo_pkg::data_t     m_data,
    input  logic                reg_wr,
    input  fifo_pkg::reg_addr_t reg_addr,
    input  fifo_pkg::reg_data_t reg_wdata,
    input  fifo_pkg::reg_data_t reg_rdata,
    input  logic                almost_full,
    input  logic                almost_empty,
    input  logic                check_en,
    input  fifo_pkg::reg_data_t check_value,
    input  logic                run_done,
    output int                  mismatch_count,
    output int                  failure_count
);

    import fifo_pkg::*;

    data_t  expected_words[$];
    int     drop_model;
    count_t af_model;
    count_t ae_model;
    logic   after_reset = 1'b0;
    logic   reported = 1'b0;
    int     mismatches = 0;
    int     failures = 0;

    assign mismatch_count = mismatches;
    assign failure_count  = failures;

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        mismatches++;
    endtask

    // Register read against the file value and the models
    task automatic check_register();
        count_t fill;
        if (reg_rdata !== check_value) begin
            report_mismatch($sformatf("reg_rdata[%0d]", reg_addr), int'(check_value),
                            int'(reg_rdata));
        end
        if (reg_addr == `REG_DROPS && reg_rdata !== reg_data_t'(drop_model)) begin
            report_mismatch("reg_rdata drop count", drop_model, int'(reg_rdata));
        end
        if (reg_addr == `REG_STATUS) begin
            fill = reg_rdata[`FIFO_PTR_WIDTH+2:2];
            if (almost_full !== (fill >= af_model)) begin
                report_mismatch("almost_full", int'(fill >= af_model), int'(almost_full));
            end
            if (almost_empty !== (fill <= ae_model)) begin
                report_mismatch("almost_empty", int'(fill <= ae_model), int'(almost_empty));
            end
        end
    endtask

    // --------------------
    // Port monitor
    // --------------------

    always @(posedge clk) begin
        if (reset) begin
            expected_words.delete();
            drop_model  = 0;
            af_model    = count_t'(`FIFO_AF_RESET);
            ae_model    = count_t'(`FIFO_AE_RESET);
            after_reset = 1'b1;
        end else begin
            if (after_reset && m_valid !== 1'b0) begin
                report_mismatch("m_valid", 0, int'(m_valid));
            end
            // Full comes out of reset set, so the write side starts closed
            if (after_reset && s_ready !== 1'b0) begin
                report_mismatch("s_ready", 0, int'(s_ready));
            end
            after_reset = 1'b0;
            if (check_en) begin
                check_register();
            end
            if (s_valid && s_ready) begin
                expected_words.push_back(s_data);
            end
            if (m_valid && m_ready) begin
                if (expected_words.size() == 0) begin
                    $display("Word %h left the read stream at %0t ns with none pending",
                             m_data, $time);
                    failures++;
                end else begin
                    if (m_data !== expected_words[0]) begin
                        report_mismatch("m_data", int'(expected_words[0]), int'(m_data));
                    end
                    void'(expected_words.pop_front());
                end
            end
            // A write to the drop register clears it, even with a drop in the same cycle
            if (reg_wr && reg_addr == `REG_DROPS) begin
                drop_model = 0;
            end else if (s_valid && !s_ready && drop_model < 65535) begin
                drop_model++;
            end
            if (reg_wr && reg_addr == `REG_AF) begin
                af_model = reg_wdata[`FIFO_PTR_WIDTH:0];
            end
            if (reg_wr && reg_addr == `REG_AE) begin
                ae_model = reg_wdata[`FIFO_PTR_WIDTH:0];
            end
        end
        if (run_done && !reported) begin
            if (expected_words.size() != 0) begin
                $display("%0d accepted words never appeared on the read stream",
                         expected_words.size());
                failures++;
            end
            $display("Checks done: %0d mismatches, %0d other failures", mismatches, failures);
            reported = 1'b1;
        end
    end

endmodule

//--- testbench/fifo_tb.sv
// Testbench top for the streaming FIFO subsystem
// Clock and reset, command file reader, stimulus driver, timeout

`timescale 1ns/1ps

`include "fifo_defs.svh"

module fifo_tb;

    import fifo_pkg::*;

    logic      clk;
    logic      reset;
    logic      s_valid;
    logic      s_ready;
    data_t     s_data;
    logic      m_valid;
    logic      m_ready;
    data_t     m_data;
    logic      reg_wr;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    logic      almost_full;
    logic      almost_empty;

    logic      check_en;
    reg_data_t check_value;
    logic      tests_done;
    logic      timed_out;
    logic      run_done;
    logic      load_failed;
    int        mismatch_count;
    int        failure_count;
    int        cycle_limit;

    // Commands from the test file
    logic [7:0] cmd_code[$];
    int         arg_a[$];
    int         arg_b[$];

    assign run_done = tests_done | timed_out;

    fifo_top uut (
        .clk          (clk),
        .reset        (reset),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .s_data       (s_data),
        .m_valid      (m_valid),
        .m_ready      (m_ready),
        .m_data       (m_data),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .almost_full  (almost_full),
        .almost_empty (almost_empty)
    );

    fifo_checker u_checker (
        .clk            (clk),
        .reset          (reset),
        .s_valid        (s_valid),
        .s_ready        (s_ready),
        .s_data         (s_data),
        .m_valid        (m_valid),
        .m_ready        (m_ready),
        .m_data         (m_data),
        .reg_wr         (reg_wr),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .almost_full    (almost_full),
        .almost_empty   (almost_empty),
        .check_en       (check_en),
        .check_value    (check_value),
        .run_done       (run_done),
        .mismatch_count (mismatch_count),
        .failure_count  (failure_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Test file reader
    // --------------------

    task automatic load_tests();
        int               fd;
        int               code;
        int               a;
        int               b;
        int               limit;
        logic [63:0]      word;
        logic [8*256-1:0] rest;
        limit = 0;
        fd = $fopen("testbench/fifo_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/fifo_tests.txt");
            load_failed = 1'b1;
        end else begin
            while ($fscanf(fd, "%s", word) == 1) begin
                if (word[7:0] == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%d %d", a, b);
                    if (code != 2) begin
                        $display("Test line %0d is incomplete", cmd_code.size() + 1);
                        load_failed = 1'b1;
                    end
                    cmd_code.push_back(word[7:0]);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                    // Budget of 20 cycles per line plus its own cycle count
                    limit += 20;
                    case (word[7:0])
                        "G":      limit += a;
                        "S", "H": limit += b;
                        default:  ;
                    endcase
                end
            end
            $fclose(fd);
            cycle_limit = limit;
        end
    endtask

    // --------------------
    // Stimulus, each task starts and ends on a falling edge
    // --------------------

    task automatic push_word(input data_t value);
        s_valid = 1'b1;
        s_data  = value;
        while (!s_ready) @(negedge clk);
        @(negedge clk);
        s_valid = 1'b0;
    endtask

    task automatic hold_word(input data_t value, input int cycles);
        s_valid = 1'b1;
        s_data  = value;
        repeat (cycles) @(negedge clk);
        s_valid = 1'b0;
    endtask

    task automatic set_ready(input logic value, input int cycles);
        m_ready = value;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic read_reg(input reg_addr_t addr, input reg_data_t expected);
        reg_addr    = addr;
        check_value = expected;
        check_en    = 1'b1;
        @(negedge clk);
        check_en    = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t value);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = value;
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    task automatic run_command(input int index);
        logic [7:0] cmd;
        int         a;
        int         b;
        cmd = cmd_code[index];
        a   = arg_a[index];
        b   = arg_b[index];
        case (cmd)
            "W": push_word(data_t'(a));
            "S": set_ready(a != 0, b);
            "G": repeat (a) @(negedge clk);
            "R": read_reg(reg_addr_t'(a), reg_data_t'(b));
            "C": write_reg(reg_addr_t'(a), reg_data_t'(b));
            "H": hold_word(data_t'(a), b);
            default: begin
                $display("Unknown command %c on test line %0d", cmd, index + 1);
                load_failed = 1'b1;
            end
        endcase
    endtask

    initial begin : main
        int i;
        reset       = 1'b1;
        s_valid     = 1'b0;
        s_data      = '0;
        m_ready     = 1'b0;
        reg_wr      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        check_en    = 1'b0;
        check_value = '0;
        tests_done  = 1'b0;
        load_failed = 1'b0;
        cycle_limit = 0;
        load_tests();
        if (!load_failed) begin
            // Two rising edges in reset, release on the falling edge after
            repeat (2) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            for (i = 0; i < cmd_code.size(); i++) begin
                run_command(i);
            end
        end
        tests_done = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (!load_failed && !timed_out && mismatch_count == 0 && failure_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Cycle counter against the limit taken from the test file
    initial begin : watchdog
        int cycles;
        timed_out = 1'b0;
        cycles    = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: tests still running after %0d cycles", cycle_limit);
        timed_out = 1'b1;
        @(posedge clk);
        @(negedge clk);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- testbench/fifo_tests.txt
# FIFO commands, one per line: letter, first number, second number, all decimal
# W word 0 | S m_ready cycles | G cycles 0 | R reg expected | C reg value | H word cycles
G 2 0
R 0 12
R 1 2
R 2 2049
R 3 0
W 4660 0
W 22136 0
S 1 2
W 43981 0
W 1 0
S 0 3
W 65535 0
S 1 12
R 2 2049
S 0 1
H 43981 20
G 4 0
R 2 66
R 3 2
H 21845 3
R 3 5
C 3 1
R 3 0
S 1 25
C 0 4
C 1 6
R 0 4
R 1 6
S 0 1
H 17 5
G 4 0
R 2 1676
H 18 2
G 4 0
R 2 1428
S 1 12
R 2 2049
R 3 0
